//--- dv/rrvModel.svh
`ifndef RRV_MODEL_SVH
`define RRV_MODEL_SVH

// Instruction classes drawn by the stimulus
localparam int KindIdle   = 0;
localparam int KindBad    = 1;  // Unsupported opcode
localparam int KindOp     = 2;
localparam int KindOpImm  = 3;
localparam int KindLui    = 4;
localparam int KindAuipc  = 5;
localparam int KindJal    = 6;
localparam int KindJalr   = 7;
localparam int KindBranch = 8;

typedef struct packed {
    logic    Valid;
    tData    Pc;
    logic    WrEn;
    tRegAddr Rd;
    tData    RdData;
    logic    Taken;
    logic    HasTarget;  // Only branches and jumps define a target
    tData    Target;
} tRetire;

tData modelRegs [`RRV_REG_COUNT];  // Architectural state, x0 kept zero

function automatic tInstr encR(input logic [6:0] Funct7, input tRegAddr Rs2,
                               input tRegAddr Rs1, input logic [2:0] Funct3,
                               input tRegAddr Rd);
    return {Funct7, Rs2, Rs1, Funct3, Rd, OP};
endfunction

function automatic tInstr encI(input tData Imm, input tRegAddr Rs1,
                               input logic [2:0] Funct3, input tRegAddr Rd,
                               input logic [6:0] Opcode);
    return {Imm[11:0], Rs1, Funct3, Rd, Opcode};
endfunction

function automatic tInstr encU(input tData Imm, input tRegAddr Rd, input logic [6:0] Opcode);
    return {Imm[31:12], Rd, Opcode};
endfunction

function automatic tInstr encB(input tData Imm, input tRegAddr Rs2, input tRegAddr Rs1,
                               input logic [2:0] Funct3);
    return {Imm[12], Imm[10:5], Rs2, Rs1, Funct3, Imm[4:1], Imm[11], BRANCH};
endfunction

function automatic tInstr encJ(input tData Imm, input tRegAddr Rd);
    return {Imm[20], Imm[10:1], Imm[11], Imm[19:12], Rd, JAL};
endfunction

// RV32I integer operations by funct3
function automatic tData aluResult(input logic [2:0] Funct3, input logic Alt,
                                   input tData A, input tData B);
    case (Funct3)
        3'd0:    return Alt ? A - B : A + B;
        3'd1:    return A << B[4:0];
        3'd2:    return ($signed(A) < $signed(B)) ? tData'(1) : tData'(0);
        3'd3:    return (A < B) ? tData'(1) : tData'(0);
        3'd4:    return A ^ B;
        3'd5:    return Alt ? tData'($signed(A) >>> B[4:0]) : A >> B[4:0];
        3'd6:    return A | B;
        default: return A & B;
    endcase
endfunction

function automatic logic branchMet(input logic [2:0] Funct3, input tData A, input tData B);
    case (Funct3)
        3'b000:  return A == B;
        3'b001:  return A != B;
        3'b100:  return $signed(A) < $signed(B);
        3'b101:  return $signed(A) >= $signed(B);
        3'b110:  return A < B;
        default: return A >= B;
    endcase
endfunction

// Executes one instruction in program order and returns its retire record
function automatic tRetire modelExecute(input int Kind, input logic [2:0] Funct3,
                                        input logic Alt, input tRegAddr Rd,
                                        input tRegAddr Rs1, input tRegAddr Rs2,
                                        input tData Imm, input tData Pc);
    tRetire Rec;
    tData   A;
    tData   B;
    tData   Res;
    logic   Wr;
    A = modelRegs[Rs1];
    B = modelRegs[Rs2];
    Rec = '0;
    Rec.Valid = 1'b1;
    Rec.Pc = Pc;
    Rec.Rd = Rd;
    Wr = 1'b1;
    Res = '0;
    case (Kind)
        KindOp:    Res = aluResult(Funct3, Alt, A, B);
        KindOpImm: Res = aluResult(Funct3, Alt, A, Imm);
        KindLui:   Res = Imm;
        KindAuipc: Res = Pc + Imm;
        KindJal, KindJalr: begin
            Res = Pc + 4;  // Link value
            Rec.Taken = 1'b1;
            Rec.HasTarget = 1'b1;
            Rec.Target = (Kind == KindJal) ? Pc + Imm : (A + Imm) & ~tData'(1);
        end
        KindBranch: begin
            Wr = 1'b0;
            Rec.Taken = branchMet(Funct3, A, B);
            Rec.HasTarget = 1'b1;
            Rec.Target = Pc + Imm;
        end
        default: begin
            Wr = 1'b0;
            Rec.Valid = 1'b0;  // Idle or unsupported
        end
    endcase
    Rec.WrEn = Wr && (Rd != '0);
    if (Rec.WrEn) begin
        Rec.RdData = Res;
        modelRegs[Rd] = Res;
    end
    return Rec;
endfunction

`endif

//--- dv/rrvTb.sv
`default_nettype none
`include "rrvCore_cfg.svh"

module rrvTb;
    import rrvPkg::*;

    `include "rrvModel.svh"

    logic    Clock;
    logic    rst;
    logic    InstrValidQ100H;
    tInstr   InstrQ100H;
    tData    PcQ100H;
    logic    RetireValidQ102H;
    tData    RetirePcQ102H;
    logic    RetireRdWrEnQ102H;
    tRegAddr RetireRdAddrQ102H;
    tData    RetireRdDataQ102H;
    logic    RetireBranchTakenQ102H;
    tData    RetireTargetQ102H;

    integer  Seed;
    int      Sent;
    tRetire  ExpQ [$];  // Records still in the pipeline with the oldest first

    rrvCore rrvCore_i (.*);

    always #50 Clock = ~Clock;

    task automatic abortRun();
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic checkData(input string Name, input tData Exp, input tData Act);
        if (Act !== Exp) begin
            $display("ERR time=%0t %s expected=%h actual=%h", $time, Name, Exp, Act);
            abortRun();
        end
    endtask

    task automatic checkRegAddr(input string Name, input tRegAddr Exp, input tRegAddr Act);
        if (Act !== Exp) begin
            $display("ERR time=%0t %s expected=%0d actual=%0d", $time, Name, Exp, Act);
            abortRun();
        end
    endtask

    task automatic checkBit(input string Name, input logic Exp, input logic Act);
        if (Act !== Exp) begin
            $display("ERR time=%0t %s expected=%b actual=%b", $time, Name, Exp, Act);
            abortRun();
        end
    endtask

    task automatic checkRetire();
        tRetire Exp;
        Exp = ExpQ.pop_front();
        checkBit("RetireValidQ102H", Exp.Valid, RetireValidQ102H);
        checkBit("RetireRdWrEnQ102H", Exp.WrEn, RetireRdWrEnQ102H);
        checkBit("RetireBranchTakenQ102H", Exp.Taken, RetireBranchTakenQ102H);
        if (Exp.Valid) begin
            checkData("RetirePcQ102H", Exp.Pc, RetirePcQ102H);
            if (Exp.WrEn) begin
                checkRegAddr("RetireRdAddrQ102H", Exp.Rd, RetireRdAddrQ102H);
                checkData("RetireRdDataQ102H", Exp.RdData, RetireRdDataQ102H);
            end
            if (Exp.HasTarget) begin
                checkData("RetireTargetQ102H", Exp.Target, RetireTargetQ102H);
            end
        end
    endtask

    // Small pool so dependencies at short distance are common
    function automatic tRegAddr pickReg();
        return tRegAddr'($unsigned($random(Seed)) % 5);
    endfunction

    task automatic issueRandom();
        int         Pick;
        int         Kind;
        logic [31:0] R;
        logic [2:0] Funct3;
        logic       Alt;
        tRegAddr    Rd;
        tRegAddr    Rs1;
        tRegAddr    Rs2;
        tData       Imm;
        tData       Pc;
        tInstr      Instr;
        Pick = $unsigned($random(Seed)) % 20;
        R = $random(Seed);
        Pc = $random(Seed);
        Pc[1:0] = 2'b00;
        Rd = pickReg();
        Rs1 = pickReg();
        Rs2 = pickReg();
        Funct3 = R[14:12];
        Alt = 1'b0;
        Imm = {{20{R[31]}}, R[31:20]};  // I immediate by default
        if (Pick < 2) Kind = KindIdle;
        else if (Pick < 3) Kind = KindBad;
        else if (Pick < 7) Kind = KindOp;
        else if (Pick < 10) Kind = KindOpImm;
        else if (Pick < 11) Kind = KindLui;
        else if (Pick < 12) Kind = KindAuipc;
        else if (Pick < 13) Kind = KindJal;
        else if (Pick < 14) Kind = KindJalr;
        else Kind = KindBranch;
        case (Kind)
            KindOp: begin
                Alt = R[30] && ((Funct3 == 3'b000) || (Funct3 == 3'b101));
                Instr = encR(Alt ? 7'b0100000 : 7'b0000000, Rs2, Rs1, Funct3, Rd);
            end
            KindOpImm: begin
                if ((Funct3 == 3'b001) || (Funct3 == 3'b101)) begin
                    Alt = R[30] && (Funct3 == 3'b101);
                    Imm = tData'(R[24:20]);  // Shift amount
                    Instr = encI(tData'({1'b0, Alt, 5'b0, R[24:20]}), Rs1, Funct3, Rd, OP_IMM);
                end else begin
                    Instr = encI(Imm, Rs1, Funct3, Rd, OP_IMM);
                end
            end
            KindLui, KindAuipc: begin
                Imm = {R[31:12], 12'b0};
                Instr = encU(Imm, Rd, (Kind == KindLui) ? LUI : AUIPC);
            end
            KindJal: begin
                Imm = {{11{R[20]}}, R[20:1], 1'b0};
                Instr = encJ(Imm, Rd);
            end
            KindJalr: begin
                Funct3 = 3'b000;
                Instr = encI(Imm, Rs1, Funct3, Rd, JALR);
            end
            KindBranch: begin
                if (Funct3[2:1] == 2'b01) begin
                    Funct3[2] = 1'b1;  // Fold unused codes onto BLTU/BGEU
                end
                Imm = {{19{R[12]}}, R[12:1], 1'b0};
                Instr = encB(Imm, Rs2, Rs1, Funct3);
            end
            KindBad: begin
                case (R[1:0])
                    2'd0:    Instr = {R[31:7], 7'b0000011};  // LOAD
                    2'd1:    Instr = {R[31:7], 7'b0100011};  // STORE
                    2'd2:    Instr = {R[31:7], 7'b0001111};
                    default: Instr = {R[31:7], 7'b1110011};  // SYSTEM
                endcase
            end
            default: Instr = R;
        endcase
        ExpQ.push_back(modelExecute(Kind, Funct3, Alt, Rd, Rs1, Rs2, Imm, Pc));
        InstrValidQ100H = (Kind != KindIdle);
        InstrQ100H = Instr;
        PcQ100H = Pc;
        if (Kind != KindIdle) begin
            Sent++;
        end
    endtask

    initial begin
        int Cycles;
        Clock = 1'b0;
        rst = 1'b1;
        InstrValidQ100H = 1'b0;
        InstrQ100H = '0;
        PcQ100H = '0;
        Seed = 21078;
        Sent = 0;
        for (int i = 0; i < `RRV_REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end
        repeat (10) @(posedge Clock);
        #10;
        rst = 1'b0;

        Cycles = 0;
        while ((RetireValidQ102H !== 1'b0) && (Cycles < 20)) begin
            @(posedge Clock);
            #10;
            Cycles++;
        end
        if (RetireValidQ102H !== 1'b0) begin
            $display("Retire valid did not settle low after reset");
            abortRun();
        end

        // The two stages ahead of retire start out empty
        ExpQ.push_back('0);
        ExpQ.push_back('0);
        Cycles = 0;
        while (Sent < 2000) begin
            if (Cycles >= 4000) begin
                $display("Stimulus did not finish within the cycle limit");
                abortRun();
            end
            @(posedge Clock);
            #10;
            checkRetire();
            issueRandom();
            Cycles++;
        end

        Cycles = 0;
        while ((ExpQ.size() > 0) && (Cycles < 10)) begin
            @(posedge Clock);
            #10;
            checkRetire();
            InstrValidQ100H = 1'b0;
            Cycles++;
        end
        if (ExpQ.size() != 0) begin
            $display("Pipeline did not drain the last instructions");
            abortRun();
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- hw/rrvCore.sv
`default_nettype none

module rrvCore (
    input  logic            Clock,
    input  logic            rst,
    input  logic            InstrValidQ100H,
    input  rrvPkg::tInstr   InstrQ100H,
    input  rrvPkg::tData    PcQ100H,
    output logic            RetireValidQ102H,
    output rrvPkg::tData    RetirePcQ102H,
    output logic            RetireRdWrEnQ102H,
    output rrvPkg::tRegAddr RetireRdAddrQ102H,
    output rrvPkg::tData    RetireRdDataQ102H,
    output logic            RetireBranchTakenQ102H,
    output rrvPkg::tData    RetireTargetQ102H
);
    import rrvPkg::*;

    // Decode to execute
    tData     PcQ101H;
    tAluOp    AluOpQ101H;
    tBranchOp BranchOpQ101H;
    logic     SelAluPcQ101H;
    logic     ImmInstrQ101H;
    logic     LuiQ101H;
    tRegAddr  RegSrc1Q101H;
    tRegAddr  RegSrc2Q101H;
    tData     PreRegRdData1Q101H;
    tData     PreRegRdData2Q101H;
    tData     ImmediateQ101H;

    // Decode to result
    logic     ValidQ101H;
    tRegAddr  RegDstQ101H;
    logic     RegWrEnQ101H;
    logic     JumpQ101H;
    logic     JalrQ101H;

    // Execute to result
    logic     BranchCondMetQ101H;
    tData     AluOutQ102H;
    tData     PcQ102H;
    tData     PcPlus4Q102H;

    // Write-back, fed to forwarding and the register file
    tRegAddr  RegDstQ102H;
    logic     RegWrEnQ102H;
    tData     RegWrDataQ102H;

    rrvDecode rrvDecode_i (
        .*
    );

    rrvExecute rrvExecute_i (
        .*
    );

    rrvResult rrvResult_i (
        .*
    );

endmodule

`default_nettype wire

//--- hw/rrvCore_cfg.svh
`ifndef RRV_CORE_CFG_SVH
`define RRV_CORE_CFG_SVH

// Architectural sizes of the integer core

`define RRV_XLEN      32  // Data path width, fixed by RV32I

`define RRV_REG_AW    5   // Register index width
`define RRV_REG_COUNT 32  // x0..x31

`endif

//--- hw/rrvDecode.sv
`default_nettype none
`include "rrvCore_cfg.svh"

module rrvDecode (
    input  logic             Clock,
    input  logic             rst,
    input  logic             InstrValidQ100H,
    input  rrvPkg::tInstr    InstrQ100H,
    input  rrvPkg::tData     PcQ100H,
    input  logic             RegWrEnQ102H,
    input  rrvPkg::tRegAddr  RegDstQ102H,
    input  rrvPkg::tData     RegWrDataQ102H,
    output logic             ValidQ101H,
    output rrvPkg::tData     PcQ101H,
    output rrvPkg::tAluOp    AluOpQ101H,
    output rrvPkg::tBranchOp BranchOpQ101H,
    output logic             SelAluPcQ101H,
    output logic             ImmInstrQ101H,
    output logic             LuiQ101H,
    output rrvPkg::tRegAddr  RegSrc1Q101H,
    output rrvPkg::tRegAddr  RegSrc2Q101H,
    output rrvPkg::tData     PreRegRdData1Q101H,
    output rrvPkg::tData     PreRegRdData2Q101H,
    output rrvPkg::tData     ImmediateQ101H,
    output rrvPkg::tRegAddr  RegDstQ101H,
    output logic             RegWrEnQ101H,
    output logic             JumpQ101H,
    output logic             JalrQ101H
);
    import rrvPkg::*;

    logic [6:0] OpcodeQ100H;
    logic [2:0] Funct3Q100H;
    logic [6:0] Funct7Q100H;
    tRegAddr    RdQ100H;
    tRegAddr    Rs1Q100H;
    tRegAddr    Rs2Q100H;
    tData       ImmIQ100H;
    tData       ImmUQ100H;
    tData       ImmBQ100H;
    tData       ImmJQ100H;
    logic       DecValidQ100H;
    logic       IssueQ100H;
    tAluOp      AluOpQ100H;
    tBranchOp   BranchOpQ100H;
    logic       SelAluPcQ100H;
    logic       ImmInstrQ100H;
    logic       LuiQ100H;
    logic       RegWrEnQ100H;
    logic       JumpQ100H;
    logic       JalrQ100H;
    tData       ImmediateQ100H;
    tData       RegRdData1Q100H;
    tData       RegRdData2Q100H;
    tData       Regs [`RRV_REG_COUNT];

    function automatic tAluOp aluOpFor(input logic [2:0] Funct3, input logic Alt);
        tAluOp Op;
        case (Funct3)
            3'b000:  Op = Alt ? SUB : ADD;
            3'b001:  Op = SLL;
            3'b010:  Op = SLT;
            3'b011:  Op = SLTU;
            3'b100:  Op = XOR;
            3'b101:  Op = Alt ? SRA : SRL;
            3'b110:  Op = OR;
            default: Op = AND;
        endcase
        return Op;
    endfunction

    assign OpcodeQ100H = InstrQ100H[6:0];
    assign RdQ100H     = InstrQ100H[11:7];
    assign Funct3Q100H = InstrQ100H[14:12];
    assign Rs1Q100H    = InstrQ100H[19:15];
    assign Rs2Q100H    = InstrQ100H[24:20];
    assign Funct7Q100H = InstrQ100H[31:25];

    assign ImmIQ100H = {{20{InstrQ100H[31]}}, InstrQ100H[31:20]};
    assign ImmUQ100H = {InstrQ100H[31:12], 12'b0};
    assign ImmBQ100H = {{19{InstrQ100H[31]}}, InstrQ100H[31], InstrQ100H[7],
                        InstrQ100H[30:25], InstrQ100H[11:8], 1'b0};
    assign ImmJQ100H = {{11{InstrQ100H[31]}}, InstrQ100H[31], InstrQ100H[19:12],
                        InstrQ100H[20], InstrQ100H[30:21], 1'b0};

    always_comb begin
        DecValidQ100H  = 1'b0;
        AluOpQ100H     = ADD;
        BranchOpQ100H  = BNONE;
        SelAluPcQ100H  = 1'b0;
        ImmInstrQ100H  = 1'b0;
        LuiQ100H       = 1'b0;
        RegWrEnQ100H   = 1'b0;
        JumpQ100H      = 1'b0;
        JalrQ100H      = 1'b0;
        ImmediateQ100H = ImmIQ100H;
        case (OpcodeQ100H)
            OP: begin
                DecValidQ100H = (Funct7Q100H == 7'b0000000) ||
                                ((Funct7Q100H == 7'b0100000) &&
                                 ((Funct3Q100H == 3'b000) || (Funct3Q100H == 3'b101)));
                AluOpQ100H    = aluOpFor(Funct3Q100H, Funct7Q100H[5]);
                RegWrEnQ100H  = 1'b1;
            end
            OP_IMM: begin
                case (Funct3Q100H)
                    3'b001:  DecValidQ100H = (Funct7Q100H == 7'b0000000);  // SLLI
                    3'b101:  DecValidQ100H = (Funct7Q100H[4:0] == 5'b0) && !Funct7Q100H[6];
                    default: DecValidQ100H = 1'b1;
                endcase
                AluOpQ100H    = aluOpFor(Funct3Q100H, (Funct3Q100H == 3'b101) && Funct7Q100H[5]);
                ImmInstrQ100H = 1'b1;
                RegWrEnQ100H  = 1'b1;
            end
            LUI: begin
                DecValidQ100H  = 1'b1;
                LuiQ100H       = 1'b1;
                ImmInstrQ100H  = 1'b1;
                ImmediateQ100H = ImmUQ100H;
                RegWrEnQ100H   = 1'b1;
            end
            AUIPC: begin
                DecValidQ100H  = 1'b1;
                SelAluPcQ100H  = 1'b1;
                ImmInstrQ100H  = 1'b1;
                ImmediateQ100H = ImmUQ100H;
                RegWrEnQ100H   = 1'b1;
            end
            JAL: begin
                DecValidQ100H  = 1'b1;
                SelAluPcQ100H  = 1'b1;  // Target = PC + J imm
                ImmInstrQ100H  = 1'b1;
                ImmediateQ100H = ImmJQ100H;
                RegWrEnQ100H   = 1'b1;
                JumpQ100H      = 1'b1;
            end
            JALR: begin
                DecValidQ100H = (Funct3Q100H == 3'b000);
                ImmInstrQ100H = 1'b1;   // Target = rs1 + I imm
                RegWrEnQ100H  = 1'b1;
                JumpQ100H     = 1'b1;
                JalrQ100H     = 1'b1;
            end
            BRANCH: begin
                DecValidQ100H  = (Funct3Q100H[2:1] != 2'b01);
                BranchOpQ100H  = tBranchOp'(Funct3Q100H);
                SelAluPcQ100H  = 1'b1;
                ImmInstrQ100H  = 1'b1;
                ImmediateQ100H = ImmBQ100H;
            end
            default: DecValidQ100H = 1'b0;  // Unsupported opcode
        endcase
    end

    assign IssueQ100H = InstrValidQ100H && DecValidQ100H;

    // Write-through read
    assign RegRdData1Q100H = (RegWrEnQ102H && (RegDstQ102H == Rs1Q100H)) ? RegWrDataQ102H :
                             Regs[Rs1Q100H];
    assign RegRdData2Q100H = (RegWrEnQ102H && (RegDstQ102H == Rs2Q100H)) ? RegWrDataQ102H :
                             Regs[Rs2Q100H];

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < `RRV_REG_COUNT; i++) begin
                Regs[i] <= '0;
            end
        end else if (RegWrEnQ102H && (RegDstQ102H != '0)) begin
            Regs[RegDstQ102H] <= RegWrDataQ102H;
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            ValidQ101H    <= 1'b0;
            RegWrEnQ101H  <= 1'b0;
            JumpQ101H     <= 1'b0;
            JalrQ101H     <= 1'b0;
            BranchOpQ101H <= BNONE;
            AluOpQ101H    <= ADD;
            SelAluPcQ101H <= 1'b0;
            ImmInstrQ101H <= 1'b0;
            LuiQ101H      <= 1'b0;
        end else begin
            ValidQ101H    <= IssueQ100H;
            RegWrEnQ101H  <= IssueQ100H && RegWrEnQ100H;
            JumpQ101H     <= IssueQ100H && JumpQ100H;
            JalrQ101H     <= IssueQ100H && JalrQ100H;
            BranchOpQ101H <= IssueQ100H ? BranchOpQ100H : BNONE;  // Bubbles never branch
            AluOpQ101H    <= AluOpQ100H;
            SelAluPcQ101H <= SelAluPcQ100H;
            ImmInstrQ101H <= ImmInstrQ100H;
            LuiQ101H      <= LuiQ100H;
        end
    end

    always_ff @(posedge Clock) begin
        PcQ101H            <= PcQ100H;
        RegSrc1Q101H       <= Rs1Q100H;
        RegSrc2Q101H       <= Rs2Q100H;
        RegDstQ101H        <= RdQ100H;
        PreRegRdData1Q101H <= RegRdData1Q100H;
        PreRegRdData2Q101H <= RegRdData2Q100H;
        ImmediateQ101H     <= ImmediateQ100H;
    end

    // A source of x0 reaches execute as zero even across a Q102H write
    x0ReadsZero1: assert property (@(posedge Clock) disable iff (rst)
        (RegSrc1Q101H == '0) |-> (PreRegRdData1Q101H == '0));
    x0ReadsZero2: assert property (@(posedge Clock) disable iff (rst)
        (RegSrc2Q101H == '0) |-> (PreRegRdData2Q101H == '0));

endmodule

`default_nettype wire

//--- hw/rrvExecute.sv
`default_nettype none

module rrvExecute (
    input  logic             Clock,
    input  logic             rst,
    input  rrvPkg::tData     PcQ101H,
    input  rrvPkg::tAluOp    AluOpQ101H,
    input  rrvPkg::tBranchOp BranchOpQ101H,
    input  logic             SelAluPcQ101H,
    input  logic             ImmInstrQ101H,
    input  logic             LuiQ101H,
    input  rrvPkg::tRegAddr  RegSrc1Q101H,
    input  rrvPkg::tRegAddr  RegSrc2Q101H,
    input  rrvPkg::tData     PreRegRdData1Q101H,
    input  rrvPkg::tData     PreRegRdData2Q101H,
    input  rrvPkg::tData     ImmediateQ101H,
    input  rrvPkg::tRegAddr  RegDstQ102H,
    input  logic             RegWrEnQ102H,
    input  rrvPkg::tData     RegWrDataQ102H,
    output logic             BranchCondMetQ101H,
    output rrvPkg::tData     AluOutQ102H,
    output rrvPkg::tData     PcQ102H,
    output rrvPkg::tData     PcPlus4Q102H
);
    import rrvPkg::*;

    logic       DataHazard1Q101H;
    logic       DataHazard2Q101H;
    tData       RegRdData1Q101H;
    tData       RegRdData2Q101H;
    tData       AluIn1Q101H;
    tData       AluIn2Q101H;
    tData       AluOutQ101H;
    logic [4:0] ShamtQ101H;

    // Instruction one ahead writes a source we need
    assign DataHazard1Q101H = RegWrEnQ102H && (RegSrc1Q101H == RegDstQ102H) &&
                              (RegSrc1Q101H != '0);
    assign DataHazard2Q101H = RegWrEnQ102H && (RegSrc2Q101H == RegDstQ102H) &&
                              (RegSrc2Q101H != '0);

    assign RegRdData1Q101H = DataHazard1Q101H ? RegWrDataQ102H : PreRegRdData1Q101H;
    assign RegRdData2Q101H = DataHazard2Q101H ? RegWrDataQ102H : PreRegRdData2Q101H;

    assign AluIn1Q101H = SelAluPcQ101H ? PcQ101H : RegRdData1Q101H;
    assign AluIn2Q101H = ImmInstrQ101H ? ImmediateQ101H : RegRdData2Q101H;
    assign ShamtQ101H  = AluIn2Q101H[4:0];  // RV32 shift amount

    always_comb begin
        case (AluOpQ101H)
            ADD:     AluOutQ101H = AluIn1Q101H + AluIn2Q101H;  // Also targets and AUIPC
            SUB:     AluOutQ101H = AluIn1Q101H - AluIn2Q101H;
            SLT:     AluOutQ101H = tData'($signed(AluIn1Q101H) < $signed(AluIn2Q101H));
            SLTU:    AluOutQ101H = tData'(AluIn1Q101H < AluIn2Q101H);
            SLL:     AluOutQ101H = AluIn1Q101H << ShamtQ101H;
            SRL:     AluOutQ101H = AluIn1Q101H >> ShamtQ101H;
            SRA:     AluOutQ101H = tData'($signed(AluIn1Q101H) >>> ShamtQ101H);
            XOR:     AluOutQ101H = AluIn1Q101H ^ AluIn2Q101H;
            OR:      AluOutQ101H = AluIn1Q101H | AluIn2Q101H;
            AND:     AluOutQ101H = AluIn1Q101H & AluIn2Q101H;
            default: AluOutQ101H = AluIn1Q101H + AluIn2Q101H;
        endcase
        if (LuiQ101H) begin
            AluOutQ101H = AluIn2Q101H;  // LUI passes the U immediate
        end
    end

    // Compare always uses the register operands, never the immediate
    always_comb begin
        case (BranchOpQ101H)
            BEQ:     BranchCondMetQ101H = (RegRdData1Q101H == RegRdData2Q101H);
            BNE:     BranchCondMetQ101H = (RegRdData1Q101H != RegRdData2Q101H);
            BLT:     BranchCondMetQ101H = ($signed(RegRdData1Q101H) < $signed(RegRdData2Q101H));
            BGE:     BranchCondMetQ101H = !($signed(RegRdData1Q101H) < $signed(RegRdData2Q101H));
            BLTU:    BranchCondMetQ101H = (RegRdData1Q101H < RegRdData2Q101H);
            BGEU:    BranchCondMetQ101H = !(RegRdData1Q101H < RegRdData2Q101H);
            default: BranchCondMetQ101H = 1'b0;  // BNONE
        endcase
    end

    always_ff @(posedge Clock) begin
        AluOutQ102H  <= AluOutQ101H;
        PcQ102H      <= PcQ101H;
        PcPlus4Q102H <= PcQ101H + tData'(4);  // Link value for jumps
    end

    // Decode must hand over a defined operation every cycle
    aluOpKnown: assert property (@(posedge Clock) disable iff (rst)
        !$isunknown(AluOpQ101H));

endmodule

`default_nettype wire

//--- hw/rrvPkg.sv
`default_nettype none
`include "rrvCore_cfg.svh"

package rrvPkg;

    typedef logic [`RRV_XLEN-1:0]   tData;     // Register values, PCs, immediates
    typedef logic [`RRV_REG_AW-1:0] tRegAddr;  // Register index
    typedef logic [31:0]            tInstr;    // Raw instruction word

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011
    } tOpcode;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        XOR,
        OR,
        AND
    } tAluOp;

    // Encoded as funct3 so a branch decodes by a plain cast
    typedef enum logic [2:0] {
        BEQ   = 3'b000,
        BNE   = 3'b001,
        BNONE = 3'b010,  // Unused funct3, marks a non-branch
        BLT   = 3'b100,
        BGE   = 3'b101,
        BLTU  = 3'b110,
        BGEU  = 3'b111
    } tBranchOp;

endpackage

`default_nettype wire

//--- hw/rrvResult.sv
`default_nettype none

module rrvResult (
    input  logic            Clock,
    input  logic            rst,
    input  logic            ValidQ101H,
    input  rrvPkg::tRegAddr RegDstQ101H,
    input  logic            RegWrEnQ101H,
    input  logic            JumpQ101H,
    input  logic            JalrQ101H,
    input  logic            BranchCondMetQ101H,
    input  rrvPkg::tData    AluOutQ102H,
    input  rrvPkg::tData    PcQ102H,
    input  rrvPkg::tData    PcPlus4Q102H,
    output rrvPkg::tRegAddr RegDstQ102H,
    output logic            RegWrEnQ102H,
    output rrvPkg::tData    RegWrDataQ102H,
    output logic            RetireValidQ102H,
    output rrvPkg::tData    RetirePcQ102H,
    output logic            RetireRdWrEnQ102H,
    output rrvPkg::tRegAddr RetireRdAddrQ102H,
    output rrvPkg::tData    RetireRdDataQ102H,
    output logic            RetireBranchTakenQ102H,
    output rrvPkg::tData    RetireTargetQ102H
);
    import rrvPkg::*;

    logic ValidQ102H;
    logic JumpQ102H;
    logic JalrQ102H;
    logic CondMetQ102H;

    always_ff @(posedge Clock) begin
        if (rst) begin
            ValidQ102H   <= 1'b0;
            RegWrEnQ102H <= 1'b0;
            JumpQ102H    <= 1'b0;
            JalrQ102H    <= 1'b0;
            CondMetQ102H <= 1'b0;
        end else begin
            ValidQ102H   <= ValidQ101H;
            RegWrEnQ102H <= ValidQ101H && RegWrEnQ101H && (RegDstQ101H != '0);  // x0 dropped
            JumpQ102H    <= ValidQ101H && JumpQ101H;
            JalrQ102H    <= ValidQ101H && JalrQ101H;
            CondMetQ102H <= ValidQ101H && BranchCondMetQ101H;
        end
    end

    always_ff @(posedge Clock) begin
        RegDstQ102H <= RegDstQ101H;
    end

    assign RegWrDataQ102H = JumpQ102H ? PcPlus4Q102H : AluOutQ102H;

    assign RetireValidQ102H       = ValidQ102H;
    assign RetirePcQ102H          = PcQ102H;
    assign RetireRdWrEnQ102H      = RegWrEnQ102H;
    assign RetireRdAddrQ102H      = RegDstQ102H;
    assign RetireRdDataQ102H      = RegWrDataQ102H;
    assign RetireBranchTakenQ102H = CondMetQ102H || JumpQ102H;
    assign RetireTargetQ102H      = JalrQ102H ? (AluOutQ102H & ~tData'(1)) : AluOutQ102H;

    // A reported write always belongs to a valid retire to a real register
    retireWrValid: assert property (@(posedge Clock) disable iff (rst)
        RetireRdWrEnQ102H |-> (RetireValidQ102H && (RetireRdAddrQ102H != '0)));

endmodule

`default_nettype wire

//--- list.f
+incdir+hw
+incdir+dv
hw/rrvPkg.sv
hw/rrvDecode.sv
hw/rrvExecute.sv
hw/rrvResult.sv
hw/rrvCore.sv
dv/rrvTb.sv
